// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

	typedef logic [15:0] addr_t; // word address
	typedef logic [15:0] word_t; // one data word
	typedef logic [4:0]  tag_t;  // addr[15:11]
	typedef logic [6:0]  set_t;  // addr[10:4]

	// addr : tttt tsss ssss bbbb, bit 0 of the offset is ignored
	localparam int TAG_LSB         = 11;
	localparam int SET_LSB         = 4;
	localparam int WORDS_PER_BLOCK = 8;

	typedef struct packed {
		logic valid; // block holds memory data
		tag_t tag;
	} meta_t;

	typedef struct packed {
		logic  rd;    // load / fetch
		logic  wr;    // store, never with rd
		addr_t addr;
		word_t wdata;
	} pipe_req_t;

	typedef struct packed {
		logic  done;  // one cycle, ends the request
		logic  busy;  // fill or write-through running
		word_t rdata; // valid with done on a read
	} pipe_rsp_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
		word_t dat;
	} wb_m2s_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_s2m_t;

endpackage

`default_nettype wire

// File: cache_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_store #(
	parameter type entry_t = logic [15:0], // tag entry or data word
	parameter int  DEPTH   = 128
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  entry_t                   wdata,
	output entry_t                   rdata
);

	entry_t mem [DEPTH]; // one entry per index

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0; // clears the valid bits of the tag array
			end
			rdata <= '0;
		end else begin
			if (we) begin
				mem[waddr] <= wdata;
			end
			rdata <= mem[raddr]; // read-first, old data on a same-index write
		end
	end

endmodule

`default_nettype wire

// File: cache_fill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               miss,      // read miss seen in the lookup cycle
	input  logic               wr_req,    // store seen in the lookup cycle
	input  cache_pkg::addr_t   addr,      // held by the pipeline until done
	input  cache_pkg::word_t   wdata,
	output cache_pkg::wb_m2s_t wb_o,
	input  cache_pkg::wb_s2m_t wb_i,
	output logic               fill_we,   // write fill word into data array
	output logic [2:0]         fill_word, // block offset of the fill word
	output logic               tag_we,    // last fill ack, mark block valid
	output logic               busy,
	output logic               finish     // cycle after the last ack
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FILL,
		ST_WRITE,
		ST_FINISH
	} state_t;

	localparam logic [2:0] LAST_WORD = 3'(cache_pkg::WORDS_PER_BLOCK - 1);

	state_t     state_q;
	logic [2:0] cnt_q; // block offset being fetched
	logic       gap_q; // stb low for one cycle after each ack
	logic       ack;

	assign ack = wb_i.ack && wb_o.cyc; // arbiter only acks the owner

	always_comb begin
		wb_o.cyc = (state_q == ST_FILL) || (state_q == ST_WRITE); // held over the whole block
		wb_o.stb = wb_o.cyc && !gap_q;
		wb_o.we  = state_q == ST_WRITE;
		wb_o.dat = wdata;
		if (state_q == ST_FILL) begin
			wb_o.adr = {addr[15:cache_pkg::SET_LSB], cnt_q, 1'b0}; // step through the block
		end else begin
			wb_o.adr = {addr[15:1], 1'b0}; // same word the data array uses
		end
	end

	assign fill_we   = (state_q == ST_FILL) && ack;
	assign fill_word = cnt_q;
	assign tag_we    = fill_we && (cnt_q == LAST_WORD);
	assign finish    = state_q == ST_FINISH;
	assign busy      = wb_o.cyc || miss || wr_req; // high already in the lookup cycle

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
			gap_q   <= 1'b0;
		end else begin
			gap_q <= ack;
			case (state_q)
				ST_IDLE: begin
					cnt_q <= '0; // fills always start at offset 0
					if (miss) begin
						state_q <= ST_FILL;
					end else if (wr_req) begin
						state_q <= ST_WRITE;
					end
				end
				ST_FILL: begin
					if (ack) begin
						cnt_q <= cnt_q + 3'd1;
						if (cnt_q == LAST_WORD) begin
							state_q <= ST_FINISH;
						end
					end
				end
				ST_WRITE: begin
					if (ack) begin
						state_q <= ST_FINISH; // single write-through cycle
					end
				end
				default: begin
					state_q <= ST_IDLE; // done goes out in finish
				end
			endcase
		end
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o.stb |-> wb_o.cyc);

	// classic handshake, the request holds still until the slave answers
	a_stb_held: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.we));

endmodule

`default_nettype wire

// File: cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache #(
	parameter bit WRITABLE = 1'b1 // 0 drops the store path, I-cache
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cache_pkg::pipe_req_t req,
	output cache_pkg::pipe_rsp_t rsp,
	output cache_pkg::wb_m2s_t   wb_o,
	input  cache_pkg::wb_s2m_t   wb_i
);

	localparam int SETS  = 2 ** $bits(cache_pkg::set_t);
	localparam int WORDS = SETS * cache_pkg::WORDS_PER_BLOCK;

	cache_pkg::tag_t          tag;
	cache_pkg::set_t          set;
	logic [2:0]               word;       // offset bits 3:1
	cache_pkg::meta_t         meta_rd;
	cache_pkg::meta_t         meta_wr;
	cache_pkg::word_t         data_rd;
	cache_pkg::word_t         data_wr;
	cache_pkg::word_t         fill_q;     // requested word caught during the fill
	logic [$clog2(WORDS)-1:0] data_raddr;
	logic [$clog2(WORDS)-1:0] data_waddr;
	logic                     look_q;     // array outputs belong to this request
	logic                     hit;
	logic                     miss;
	logic                     wr_req;
	logic                     wr_hit_we;
	logic                     data_we;
	logic                     fill_we;
	logic [2:0]               fill_word;
	logic                     tag_we;
	logic                     fsm_busy;
	logic                     finish;

	assign tag  = req.addr[cache_pkg::TAG_LSB +: $bits(cache_pkg::tag_t)];
	assign set  = req.addr[cache_pkg::SET_LSB +: $bits(cache_pkg::set_t)];
	assign word = req.addr[cache_pkg::SET_LSB-1:1];

	assign hit    = meta_rd.valid && (meta_rd.tag == tag);
	assign miss   = look_q && req.rd && !hit;
	assign wr_req = WRITABLE ? (look_q && req.wr) : 1'b0; // write-through on hit and miss

	// store hit updates the word together with the memory ack
	assign wr_hit_we = WRITABLE && req.wr && hit && wb_i.ack;
	assign data_we   = fill_we || wr_hit_we;
	assign data_wr   = fill_we ? wb_i.dat : req.wdata;

	assign data_raddr = {set, word};
	assign data_waddr = {set, (fill_we ? fill_word : word)};
	assign meta_wr    = '{valid: 1'b1, tag: tag};

	always_comb begin
		rsp.done  = finish || (look_q && req.rd && hit); // hit answers one cycle after request
		rsp.busy  = fsm_busy;
		rsp.rdata = finish ? fill_q : data_rd;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			look_q <= 1'b0;
		end else begin
			look_q <= (req.rd || req.wr) && !look_q && !fsm_busy && !rsp.done;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_we && (fill_word == word)) begin
			fill_q <= wb_i.dat;
		end
	end

	cache_store #(
		.entry_t (cache_pkg::meta_t),
		.DEPTH   (SETS)
	) tag_store_i (
		.clk   (clk),
		.rst_n (rst_n),
		.raddr (set),
		.we    (tag_we),
		.waddr (set),
		.wdata (meta_wr),
		.rdata (meta_rd)
	);

	cache_store #(
		.entry_t (cache_pkg::word_t),
		.DEPTH   (WORDS)
	) data_store_i (
		.clk   (clk),
		.rst_n (rst_n),
		.raddr (data_raddr),
		.we    (data_we),
		.waddr (data_waddr),
		.wdata (data_wr),
		.rdata (data_rd)
	);

	cache_fill_fsm fill_fsm_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.miss      (miss),
		.wr_req    (wr_req),
		.addr      (req.addr),
		.wdata     (req.wdata),
		.wb_o      (wb_o),
		.wb_i      (wb_i),
		.fill_we   (fill_we),
		.fill_word (fill_word),
		.tag_we    (tag_we),
		.busy      (fsm_busy),
		.finish    (finish)
	);

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(req.rd && req.wr));

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.done |=> !rsp.done); // requester gets one cycle to move on

	if (!WRITABLE) begin : g_read_only
		a_no_store: assert property (@(posedge clk) disable iff (!rst_n)
			!req.wr);
	end

endmodule

`default_nettype wire

// File: wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
	input  logic               clk,
	input  logic               rst_n,
	input  cache_pkg::wb_m2s_t m0_i, // I-cache
	output cache_pkg::wb_s2m_t m0_o,
	input  cache_pkg::wb_m2s_t m1_i, // D-cache
	output cache_pkg::wb_s2m_t m1_o,
	output cache_pkg::wb_m2s_t s_o,
	input  cache_pkg::wb_s2m_t s_i
);

	logic [1:0]         grant_q; // one-hot owner, 00 when idle
	logic               last_q;  // last winner, 0 = m0
	logic               pick;    // winner if granted now
	cache_pkg::wb_m2s_t own_req;

	assign pick    = (m0_i.cyc && m1_i.cyc) ? !last_q : m1_i.cyc; // favor the loser
	assign own_req = grant_q[1] ? m1_i : m0_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_q <= 2'b00;
			last_q  <= 1'b0;
		end else if (grant_q == 2'b00) begin
			if (m0_i.cyc || m1_i.cyc) begin
				grant_q <= pick ? 2'b10 : 2'b01;
				last_q  <= pick;
			end
		end else if (!own_req.cyc) begin
			grant_q <= 2'b00; // owner released the bus
		end
	end

	always_comb begin
		s_o      = (grant_q != 2'b00) ? own_req : '0;
		m0_o.ack = s_i.ack && grant_q[0]; // other master stalls on ack low
		m0_o.dat = grant_q[0] ? s_i.dat : '0;
		m1_o.ack = s_i.ack && grant_q[1];
		m1_o.dat = grant_q[1] ? s_i.dat : '0;
	end

	// slave answers only within the owner's cycle, never into a changed grant
	a_ack_owner: assert property (@(posedge clk) disable iff (!rst_n)
		s_i.ack |-> (grant_q[0] && m0_i.cyc) || (grant_q[1] && m1_i.cyc));

endmodule

`default_nettype wire

// File: main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory #(
	parameter int WAIT_STATES = 2 // ack comes WAIT_STATES+1 cycles after stb
) (
	input  logic               clk,
	input  logic               rst_n,
	input  cache_pkg::wb_m2s_t wb_i,
	output cache_pkg::wb_s2m_t wb_o
);

	localparam int WORDS = 2 ** $bits(cache_pkg::addr_t);

	cache_pkg::word_t mem [WORDS];
	cache_pkg::word_t dat_q;  // read data, valid with ack
	logic [7:0]       wait_q; // wait states spent on this transfer
	logic             ack_q;
	logic             req;
	logic             serve;  // last wait state, answer next cycle

	assign req   = wb_i.cyc && wb_i.stb && !ack_q; // stb still high in the ack cycle
	assign serve = req && (wait_q == 8'(WAIT_STATES));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < WORDS; i++) begin
				mem[i] <= cache_pkg::word_t'(i) ^ 16'h5a5a; // known pattern
			end
			wait_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			ack_q <= serve;
			if (serve) begin
				wait_q <= '0;
				if (wb_i.we) begin
					mem[wb_i.adr] <= wb_i.dat;
				end
			end else if (req) begin
				wait_q <= wait_q + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (serve) begin
			dat_q <= mem[wb_i.adr]; // old word on a write, master ignores it
		end
	end

	always_comb begin
		wb_o.ack = ack_q;
		wb_o.dat = dat_q;
	end

endmodule

`default_nettype wire

// File: mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
	parameter int WAIT_STATES = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cache_pkg::pipe_req_t i_req, // fetch side
	output cache_pkg::pipe_rsp_t i_rsp,
	input  cache_pkg::pipe_req_t d_req, // load / store side
	output cache_pkg::pipe_rsp_t d_rsp
);

	cache_pkg::wb_m2s_t ic_m2s;
	cache_pkg::wb_s2m_t ic_s2m;
	cache_pkg::wb_m2s_t dc_m2s;
	cache_pkg::wb_s2m_t dc_s2m;
	cache_pkg::wb_m2s_t mem_m2s;
	cache_pkg::wb_s2m_t mem_s2m;

	cache #(
		.WRITABLE (1'b0)
	) icache_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (i_req),
		.rsp   (i_rsp),
		.wb_o  (ic_m2s),
		.wb_i  (ic_s2m)
	);

	cache #(
		.WRITABLE (1'b1)
	) dcache_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (d_req),
		.rsp   (d_rsp),
		.wb_o  (dc_m2s),
		.wb_i  (dc_s2m)
	);

	wb_arbiter arbiter_i (
		.clk   (clk),
		.rst_n (rst_n),
		.m0_i  (ic_m2s), // master 0 counts as last winner after reset
		.m0_o  (ic_s2m),
		.m1_i  (dc_m2s),
		.m1_o  (dc_s2m),
		.s_o   (mem_m2s),
		.s_i   (mem_s2m)
	);

	main_memory #(
		.WAIT_STATES (WAIT_STATES)
	) memory_i (
		.clk   (clk),
		.rst_n (rst_n),
		.wb_i  (mem_m2s),
		.wb_o  (mem_s2m)
	);

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	initial begin
		rst_n = 1'b0;                           // reset held from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;                           // released between rising edges
	end

endmodule

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int TIMEOUT_CYCLES = 400; // two block fills back to back fit easily

	logic                 clk;
	logic                 rst_n;
	cache_pkg::pipe_req_t i_req;
	cache_pkg::pipe_rsp_t i_rsp;
	cache_pkg::pipe_req_t d_req;
	cache_pkg::pipe_rsp_t d_rsp;
	cache_pkg::word_t     shadow [65536]; // expected main memory contents
	logic [31:0]          lcg_q;

	tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(4)) clock_i (.clk(clk), .rst_n(rst_n));

	mem_subsystem_top #(
		.WAIT_STATES (2)
	) dut_i (
		.clk   (clk),
		.rst_n (rst_n),
		.i_req (i_req),
		.i_rsp (i_rsp),
		.d_req (d_req),
		.d_rsp (d_rsp)
	);

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input cache_pkg::word_t exp,
		input cache_pkg::word_t act);
		if (act !== exp) begin
			stop_failed($sformatf("ERR %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_done_timing(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_failed($sformatf("ERR %s done timing expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_failed($sformatf("ERR %s busy expected %b actual %b", name, exp, act));
		end
	endtask

	function automatic cache_pkg::word_t rand_word();
		lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
		return lcg_q[31:16]; // upper bits, longer period
	endfunction

	function automatic cache_pkg::addr_t rand_addr(input logic hi);
		cache_pkg::word_t r;
		r = rand_word();
		return {hi, r[14:1], 1'b0}; // hi half takes stores, I side reads the low half
	endfunction

	function automatic cache_pkg::word_t expect_word(input cache_pkg::addr_t a);
		return shadow[{a[15:1], 1'b0}]; // offset bit 0 selects no word
	endfunction

	task automatic wait_reset_done();
		int n;
		for (n = 0; n < 20 && rst_n !== 1'b1; n++) begin
			@(negedge clk);
		end
		if (rst_n !== 1'b1) begin
			stop_failed("reset was never released");
		end
	endtask

	// drives one request per side, an idle side passes an empty request
	task automatic access_pair(
		input  string                name,
		input  cache_pkg::pipe_req_t ireq,
		input  cache_pkg::pipe_req_t dreq,
		output cache_pkg::word_t     irdata,
		output cache_pkg::word_t     drdata,
		output int                   dcycles
	);
		logic i_seen;
		logic d_seen;
		logic i_fin;
		logic d_fin;
		logic i_busy;
		logic d_busy;
		int   n;
		i_seen  = 1'b0;
		d_seen  = 1'b0;
		i_fin   = !(ireq.rd || ireq.wr);
		d_fin   = !(dreq.rd || dreq.wr);
		i_busy  = 1'b0;
		d_busy  = 1'b0;
		irdata  = '0;
		drdata  = '0;
		dcycles = 0;
		@(negedge clk);
		i_req = ireq;
		d_req = dreq;
		for (n = 1; n <= TIMEOUT_CYCLES && !(i_fin && d_fin); n++) begin
			@(negedge clk);
			if (i_seen && !i_fin) begin
				check_done_timing(name, 1'b0, i_rsp.done); // pulse is one cycle
				i_req = '0;
				i_fin = 1'b1;
			end else if (!i_fin) begin
				i_busy = i_busy || i_rsp.busy;
				if (i_rsp.done) begin
					i_seen = 1'b1;
					irdata = i_rsp.rdata;
					check_busy(name, n > 1, i_busy); // only a one-cycle hit skips the bus
				end
			end
			if (d_seen && !d_fin) begin
				check_done_timing(name, 1'b0, d_rsp.done);
				d_req = '0;
				d_fin = 1'b1;
			end else if (!d_fin) begin
				d_busy = d_busy || d_rsp.busy;
				if (d_rsp.done) begin
					d_seen  = 1'b1;
					drdata  = d_rsp.rdata;
					dcycles = n; // 1 means done in the cycle after the request
					check_busy(name, n > 1, d_busy);
				end
			end
		end
		if (!(i_fin && d_fin)) begin
			stop_failed($sformatf("timeout: %s saw no done within %0d cycles", name,
				TIMEOUT_CYCLES));
		end
	endtask

	task automatic d_read(input string name, input cache_pkg::addr_t a, output int cycles);
		cache_pkg::pipe_req_t req;
		cache_pkg::word_t     iw;
		cache_pkg::word_t     dw;
		req = '{rd: 1'b1, wr: 1'b0, addr: a, wdata: '0};
		access_pair(name, '0, req, iw, dw, cycles);
		check_word(name, expect_word(a), dw);
	endtask

	task automatic d_write(input string name, input cache_pkg::addr_t a,
		input cache_pkg::word_t v);
		cache_pkg::pipe_req_t req;
		cache_pkg::word_t     iw;
		cache_pkg::word_t     dw;
		int                   cycles;
		req = '{rd: 1'b0, wr: 1'b1, addr: a, wdata: v};
		access_pair(name, '0, req, iw, dw, cycles);
		shadow[{a[15:1], 1'b0}] = v; // every store reaches memory
	endtask

	task automatic i_read(input string name, input cache_pkg::addr_t a);
		cache_pkg::pipe_req_t req;
		cache_pkg::word_t     iw;
		cache_pkg::word_t     dw;
		int                   cycles;
		req = '{rd: 1'b1, wr: 1'b0, addr: a, wdata: '0};
		access_pair(name, req, '0, iw, dw, cycles);
		check_word(name, expect_word(a), iw);
	endtask

	task automatic read_miss_fill();
		int cycles;
		for (int k = 0; k < 3; k++) begin
			d_read("read_miss_fill d", rand_addr(1'b1), cycles);
			i_read("read_miss_fill i", rand_addr(1'b0));
		end
	endtask

	task automatic read_hit_same_block();
		cache_pkg::addr_t base;
		int               cycles;
		base = rand_addr(1'b0) & 16'hfff0;
		d_read("read_hit_same_block", base, cycles); // brings the block in
		for (int k = 0; k < 8; k++) begin
			d_read("read_hit_same_block", base | cache_pkg::addr_t'(2 * k + (k % 2)), cycles);
			check_done_timing("read_hit_same_block", 1'b1, cycles == 1);
		end
	endtask

	task automatic write_through();
		cache_pkg::addr_t a;
		int               cycles;
		a = rand_addr(1'b1);
		d_read("write_through", a, cycles);
		d_write("write_through", a, rand_word());
		d_read("write_through", a, cycles);
		check_done_timing("write_through", 1'b1, cycles == 1); // D-cache took the store
		i_read("write_through i", a);                          // fresh fill from memory
	endtask

	task automatic write_no_allocate();
		cache_pkg::addr_t a;
		int               cycles;
		a = rand_addr(1'b1);
		d_read("write_no_allocate", a ^ 16'h0800, cycles); // same set, other tag
		d_write("write_no_allocate", a, rand_word());
		d_read("write_no_allocate", a, cycles);
		check_done_timing("write_no_allocate", 1'b1, cycles > 1); // still a miss
	endtask

	task automatic conflict_eviction();
		cache_pkg::addr_t a;
		cache_pkg::addr_t b;
		int               cycles;
		a = rand_addr(1'b1);
		b = a ^ 16'h2000; // differs in the tag only
		for (int r = 0; r < 4; r++) begin
			d_read("conflict_eviction a", a, cycles);
			if (r % 2 == 1) begin
				d_write("conflict_eviction", a, rand_word()); // a cached, store hits
			end
			d_read("conflict_eviction b", b, cycles);
			d_write("conflict_eviction", a, rand_word()); // a evicted by b
		end
		d_read("conflict_eviction a", a, cycles);
	endtask

	task automatic concurrent_masters();
		cache_pkg::pipe_req_t ireq;
		cache_pkg::pipe_req_t dreq;
		cache_pkg::word_t     iw;
		cache_pkg::word_t     dw;
		int                   cycles;
		for (int r = 0; r < 3; r++) begin
			ireq = '{rd: 1'b1, wr: 1'b0, addr: rand_addr(1'b0), wdata: '0};
			dreq = '{rd: 1'b1, wr: 1'b0, addr: rand_addr(1'b1), wdata: '0};
			access_pair("concurrent_masters", ireq, dreq, iw, dw, cycles); // both miss at once
			check_word("concurrent_masters i", expect_word(ireq.addr), iw);
			check_word("concurrent_masters d", expect_word(dreq.addr), dw);
		end
	endtask

	initial begin
		i_req = '0;
		d_req = '0;
		lcg_q = 32'hc25a;
		for (int i = 0; i < 65536; i++) begin
			shadow[i[15:0]] = cache_pkg::word_t'(i) ^ 16'h5a5a; // memory reset pattern
		end
		wait_reset_done();
		read_miss_fill();
		read_hit_same_block();
		write_through();
		write_no_allocate();
		conflict_eviction();
		concurrent_masters();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
cache_pkg.sv
cache_store.sv
cache_fill_fsm.sv
cache.sv
wb_arbiter.sv
main_memory.sv
mem_subsystem_top.sv
tb_clock.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim
